// File: bch_syndrome/bch_syndrome.sv
// BCH syndrome calculator, word-serial Horner accumulation of S1 and S3
`timescale 1ns/1ns

module bch_syndrome (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             word_avail,
	input  logic                             word_first,
	input  logic [bch_pkg::WORD_BITS-1:0]    word_bits,
	input  logic                             res_space,
	output logic                             word_take,
	output logic                             syn_done,
	output bch_pkg::gf_elem_t                syn_s1,
	output bch_pkg::gf_elem_t                syn_s3
);

	localparam int CNT_W = $clog2(bch_pkg::WORDS_PER_CW);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(bch_pkg::WORDS_PER_CW - 1);

	// Powers of alpha needed to step three bits at a time
	localparam bch_pkg::gf_elem_t A1 = bch_pkg::gf_alpha_pow(1);
	localparam bch_pkg::gf_elem_t A2 = bch_pkg::gf_alpha_pow(2);
	localparam bch_pkg::gf_elem_t A3 = bch_pkg::gf_alpha_pow(3);
	localparam bch_pkg::gf_elem_t A6 = bch_pkg::gf_alpha_pow(6);
	localparam bch_pkg::gf_elem_t A9 = bch_pkg::gf_alpha_pow(9);

	logic              busy;
	logic [CNT_W-1:0]  cnt;
	logic              last_word;
	bch_pkg::gf_elem_t s1_base;
	bch_pkg::gf_elem_t s3_base;
	bch_pkg::gf_elem_t s1_next;
	bch_pkg::gf_elem_t s3_next;
	bch_pkg::gf_elem_t b2_mask;
	bch_pkg::gf_elem_t b1_mask;
	bch_pkg::gf_elem_t b0_term;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Word acceptance
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Mid-codeword words always go in; a new codeword waits for result room.
	// The done cycle counts as idle, so codewords can run back to back
	assign word_take = word_avail && (busy || (word_first && res_space));
	assign last_word = (cnt == LAST_WORD);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Horner step over three bits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		s1_base = word_first ? '0 : syn_s1;
		s3_base = word_first ? '0 : syn_s3;
		b2_mask = {bch_pkg::GF_M{word_bits[2]}};
		b1_mask = {bch_pkg::GF_M{word_bits[1]}};
		b0_term = bch_pkg::gf_elem_t'(word_bits[0]);
		// S1 <- S1*a^3 + b2*a^2 + b1*a + b0
		s1_next = bch_pkg::gf_mul(s1_base, A3) ^ (b2_mask & A2) ^ (b1_mask & A1) ^ b0_term;
		// S3 <- S3*a^9 + b2*a^6 + b1*a^3 + b0
		s3_next = bch_pkg::gf_mul(s3_base, A9) ^ (b2_mask & A6) ^ (b1_mask & A3) ^ b0_term;
	end

	always_ff @(posedge clk) begin
		if (word_take) begin
			syn_s1 <= s1_next;
			syn_s3 <= s3_next;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Codeword framing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy     <= 1'b0;
			cnt      <= '0;
			syn_done <= 1'b0;
		end else begin
			syn_done <= word_take && busy && last_word;
			if (word_take) begin
				if (!busy) begin
					// First word of a codeword
					busy <= 1'b1;
					cnt  <= CNT_W'(1);
				end else if (last_word) begin
					busy <= 1'b0;
					cnt  <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// Source framing seen through the input queue
	ap_no_first_mid: assert property (@(posedge clk) disable iff (!rst_n)
		(word_avail && busy) |-> !word_first)
		else $error("first-flagged word arrived mid-codeword");

	ap_no_orphan_word: assert property (@(posedge clk) disable iff (!rst_n)
		(word_avail && !busy) |-> word_first)
		else $error("non-first word arrived while idle");

endmodule

// File: bch_syndrome/bch_syndrome_expand.sv
// BCH syndrome expansion, even syndromes by squaring plus error flags
`timescale 1ns/1ns

module bch_syndrome_expand (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              syn_done,
	input  bch_pkg::gf_elem_t syn_s1,
	input  bch_pkg::gf_elem_t syn_s3,
	output logic              res_valid,
	output bch_pkg::result_t  res_data
);

	// S1 .. S2t, binary code so S2j = Sj^2
	bch_pkg::gf_elem_t syn [1:2*bch_pkg::CODE_T];
	bch_pkg::gf_elem_t s1_cubed;
	logic              any_nonzero;

	always_comb begin
		syn[1] = syn_s1;
		syn[2] = bch_pkg::gf_square(syn_s1);
		syn[3] = syn_s3;
		syn[4] = bch_pkg::gf_square(syn[2]);
		any_nonzero = 1'b0;
		for (int i = 1; i <= 2 * bch_pkg::CODE_T; i++) begin
			any_nonzero |= (syn[i] != '0);
		end
		s1_cubed = bch_pkg::gf_mul(syn[2], syn_s1);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result register, one cycle after syn_done
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= syn_done;
		end
	end

	always_ff @(posedge clk) begin
		if (syn_done) begin
			res_data.s1             <= syn[1];
			res_data.s2             <= syn[2];
			res_data.s3             <= syn[3];
			res_data.s4             <= syn[4];
			res_data.errors_present <= any_nonzero;
			// One error at X gives S1 = X and S3 = X^3
			res_data.single_error   <= (syn_s1 != '0) && (syn_s3 == s1_cubed);
		end
	end

endmodule

// File: common/bch_pkg.sv
// BCH(15,7) package with code constants, GF(2^4) arithmetic and payload types
package bch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Code constants
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Field size and code shape
	localparam int GF_M   = 4;
	localparam int CODE_N = 15;
	localparam int CODE_K = 7;
	localparam int CODE_T = 2;

	// Received bits per input word, 15 splits evenly into 5 words
	localparam int WORD_BITS    = 3;
	localparam int WORDS_PER_CW = CODE_N / WORD_BITS;

	// Field polynomial x^4 + x + 1
	localparam logic [GF_M:0] PRIM_POLY = 5'b10011;

	// Queue depths and credit counts
	localparam int IN_DEPTH    = 4;
	localparam int OUT_CREDITS = 2;
	localparam int RES_DEPTH   = 4;
	localparam int RES_RESERVE = 3;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [GF_M-1:0] gf_elem_t;

	// One input word, bit 2 of bits is the earliest received bit
	typedef struct packed {
		logic                 first;
		logic [WORD_BITS-1:0] bits;
	} cw_word_t;

	// One result per codeword
	typedef struct packed {
		gf_elem_t s1;
		gf_elem_t s2;
		gf_elem_t s3;
		gf_elem_t s4;
		logic     errors_present;
		logic     single_error;
	} result_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// GF(2^4) arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Shift and add multiply, reducing by the field polynomial each step
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t        prod;
		logic [GF_M:0]   sh;
		prod = '0;
		sh   = {1'b0, a};
		for (int i = 0; i < GF_M; i++) begin
			if (b[i]) begin
				prod ^= sh[GF_M-1:0];
			end
			sh = sh << 1;
			if (sh[GF_M]) begin
				sh ^= PRIM_POLY;
			end
		end
		return prod;
	endfunction

	function automatic gf_elem_t gf_square(input gf_elem_t a);
		return gf_mul(a, a);
	endfunction

	// alpha^e, used mostly to build constants at elaboration
	function automatic gf_elem_t gf_alpha_pow(input int e);
		gf_elem_t r;
		int       n;
		r = gf_elem_t'(1);
		n = e % CODE_N;
		for (int i = 0; i < n; i++) begin
			r = gf_mul(r, gf_elem_t'(2));
		end
		return r;
	endfunction

endpackage

// File: logic/bch_front.sv
// BCH(15,7) decoder front end, input queue to syndromes to result queue
`timescale 1ns/1ns

module bch_front (
	input  logic                          clk,
	input  logic                          rst_n,
	// Source side
	input  logic                          in_valid,
	input  logic                          in_first,
	input  logic [bch_pkg::WORD_BITS-1:0] in_bits,
	output logic                          in_credit,
	// Consumer side
	output logic                          out_valid,
	output bch_pkg::gf_elem_t             out_s1,
	output bch_pkg::gf_elem_t             out_s2,
	output bch_pkg::gf_elem_t             out_s3,
	output bch_pkg::gf_elem_t             out_s4,
	output logic                          out_errors_present,
	output logic                          out_single_error,
	input  logic                          out_credit
);

	bch_pkg::cw_word_t in_word;
	bch_pkg::cw_word_t word_head;
	logic              word_avail;
	logic              word_take;
	logic              res_space;
	logic              syn_done;
	bch_pkg::gf_elem_t syn_s1;
	bch_pkg::gf_elem_t syn_s3;
	logic              res_valid;
	bch_pkg::result_t  res_data;
	bch_pkg::result_t  res_head;

	assign in_word            = '{first: in_first, bits: in_bits};
	assign out_s1             = res_head.s1;
	assign out_s2             = res_head.s2;
	assign out_s3             = res_head.s3;
	assign out_s4             = res_head.s4;
	assign out_errors_present = res_head.errors_present;
	assign out_single_error   = res_head.single_error;

	// Input words, popped directly by the syndrome calculator
	credit_fifo #(
		.payload_t   (bch_pkg::cw_word_t),
		.DEPTH       (bch_pkg::IN_DEPTH),
		.OUT_CREDITS (0),
		.TAKE_MODE   (1'b1)
	) u_in_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (in_valid),
		.push_data  (in_word),
		.pop_credit (in_credit),
		.out_valid  (word_avail),
		.out_data   (word_head),
		.out_credit (word_take),
		.space      ()
	);

	bch_syndrome u_syndrome (
		.clk        (clk),
		.rst_n      (rst_n),
		.word_avail (word_avail),
		.word_first (word_head.first),
		.word_bits  (word_head.bits),
		.res_space  (res_space),
		.word_take  (word_take),
		.syn_done   (syn_done),
		.syn_s1     (syn_s1),
		.syn_s3     (syn_s3)
	);

	bch_syndrome_expand u_expand (
		.clk       (clk),
		.rst_n     (rst_n),
		.syn_done  (syn_done),
		.syn_s1    (syn_s1),
		.syn_s3    (syn_s3),
		.res_valid (res_valid),
		.res_data  (res_data)
	);

	// Results, released against consumer credits
	credit_fifo #(
		.payload_t   (bch_pkg::result_t),
		.DEPTH       (bch_pkg::RES_DEPTH),
		.OUT_CREDITS (bch_pkg::OUT_CREDITS),
		.TAKE_MODE   (1'b0)
	) u_res_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (res_valid),
		.push_data  (res_data),
		.pop_credit (),
		.out_valid  (out_valid),
		.out_data   (res_head),
		.out_credit (out_credit),
		.space      (res_space)
	);

endmodule

// File: logic/credit_fifo.sv
// Credit-controlled circular queue, generic over its payload type
`timescale 1ns/1ns

module credit_fifo #(
	parameter type payload_t   = logic,
	parameter int  DEPTH       = 4,
	parameter int  OUT_CREDITS = 2,
	parameter bit  TAKE_MODE   = 1'b0
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	output logic     pop_credit,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_credit,
	output logic     space
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 2);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             not_empty;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign not_empty = (count != '0);

	// Take mode presents the head and lets the reader pop through out_credit,
	// otherwise the head leaves on its own whenever a downstream credit is held
	assign out_valid = TAKE_MODE ? not_empty : (not_empty && (credits != '0));
	assign pop       = TAKE_MODE ? (out_credit && not_empty) : out_valid;
	assign out_data  = mem[rd_ptr];

	// Room for a whole codeword still to come
	assign space = (DEPTH - int'(count)) >= bch_pkg::RES_RESERVE;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pointers, occupancy and credits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			pop_credit <= 1'b0;
			credits    <= CRD_W'(OUT_CREDITS);
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count      <= count + CNT_W'(push) - CNT_W'(pop);
			// Freed slot goes back upstream one cycle later
			pop_credit <= pop;
			if (!TAKE_MODE) begin
				credits <= credits + CRD_W'(out_credit) - CRD_W'(pop);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Upstream sender must respect its credits
	ap_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push |-> (count != CNT_W'(DEPTH)))
		else $error("credit_fifo push while full");

	// Consumer returns no more credits than it was given
	ap_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= CRD_W'(OUT_CREDITS))
		else $error("credit_fifo credit counter above its initial value");

endmodule

// File: project.f
+incdir+verif
common/bch_pkg.sv
logic/credit_fifo.sv
bch_syndrome/bch_syndrome.sv
bch_syndrome/bch_syndrome_expand.sv
logic/bch_front.sv
verif/tb_bch_front.sv

// File: verif/bch_ref.svh
// BCH(15,7) reference model with random bit source, field math, encoder and syndromes
`ifndef BCH_REF_SVH
`define BCH_REF_SVH

	// Fibonacci LFSR with taps 32, 22, 2, 1, one new bit per step
	function automatic logic lfsr_bit(inout logic [31:0] state);
		logic fb;
		fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
		state = {state[30:0], fb};
		return fb;
	endfunction

	function automatic int draw_bits(inout logic [31:0] state, input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_bit(state));
		end
		return v;
	endfunction

	// Full carry-less product first, then reduce by x^4 + x + 1
	function automatic logic [3:0] field_mul(input logic [3:0] a, input logic [3:0] b);
		logic [6:0] p;
		p = '0;
		for (int i = 0; i < 4; i++) begin
			if (b[i]) begin
				p ^= 7'(a) << i;
			end
		end
		for (int i = 6; i >= 4; i--) begin
			if (p[i]) begin
				p ^= 7'(5'b10011) << (i - 4);
			end
		end
		return p[3:0];
	endfunction

	function automatic logic [3:0] field_square(input logic [3:0] a);
		return field_mul(a, a);
	endfunction

	// Systematic encoding, message in the top 7 bits, remainder of m(x)*x^8 below
	function automatic logic [14:0] encode_message(input logic [6:0] msg);
		logic [14:0] rem;
		rem = {msg, 8'h00};
		for (int i = 14; i >= 8; i--) begin
			if (rem[i]) begin
				rem ^= 15'(9'h1D1) << (i - 8);
			end
		end
		return {msg, rem[7:0]};
	endfunction

	// r(beta) with bit i of the word as the coefficient of x^i
	function automatic logic [3:0] poly_eval(input logic [14:0] r, input logic [3:0] beta);
		logic [3:0] acc;
		acc = '0;
		for (int i = 14; i >= 0; i--) begin
			acc = field_mul(acc, beta) ^ {3'b000, r[i]};
		end
		return acc;
	endfunction

`endif

// File: verif/tb_bch_front.sv
// Testbench for the BCH(15,7) front end, random codewords under credit flow on both sides
`timescale 1ns/1ns

module tb_bch_front;

	localparam int          NUM_CW     = 200;
	localparam int          STALL_AT   = 40;
	localparam int          STALL_LEN  = 300;
	localparam time         CLK_PERIOD = 100;
	localparam time         RUN_LIMIT  = NUM_CW * bch_pkg::WORDS_PER_CW * CLK_PERIOD * 8;
	localparam logic [31:0] SEED       = 32'h111f_8d84;

	logic              clk;
	logic              rst_n;
	logic              in_valid;
	logic              in_first;
	logic [2:0]        in_bits;
	logic              in_credit;
	logic              out_valid;
	bch_pkg::gf_elem_t out_s1;
	bch_pkg::gf_elem_t out_s2;
	bch_pkg::gf_elem_t out_s3;
	bch_pkg::gf_elem_t out_s4;
	logic              out_errors_present;
	logic              out_single_error;
	logic              out_credit;

	bch_pkg::result_t  exp_res [NUM_CW];
	int                exp_weight [NUM_CW];
	bch_pkg::result_t  exp_head;
	int                head_weight;
	int                rx_idx;
	int                cons_credits;
	int                src_back;
	int                src_avail;
	int                words_sent;
	int                credits_given;
	int                mismatch_errors;
	int                protocol_errors;
	logic [31:0]       msg_lfsr;
	logic [31:0]       delay_lfsr;

	`include "bch_ref.svh"

	bch_front dut0 (
		.clk                (clk),
		.rst_n              (rst_n),
		.in_valid           (in_valid),
		.in_first           (in_first),
		.in_bits            (in_bits),
		.in_credit          (in_credit),
		.out_valid          (out_valid),
		.out_s1             (out_s1),
		.out_s2             (out_s2),
		.out_s3             (out_s3),
		.out_s4             (out_s4),
		.out_errors_present (out_errors_present),
		.out_single_error   (out_single_error),
		.out_credit         (out_credit)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	assign exp_head    = exp_res[(rx_idx < NUM_CW) ? rx_idx : NUM_CW - 1];
	assign head_weight = exp_weight[(rx_idx < NUM_CW) ? rx_idx : NUM_CW - 1];
	assign src_avail   = bch_pkg::IN_DEPTH - words_sent + src_back;

	// Random message, encode, flip up to three distinct bits, store the expected result
	task automatic build_codeword(input int idx, output logic [14:0] rx);
		logic [6:0]  msg;
		logic [14:0] flip_mask;
		logic [3:0]  s1;
		logic [3:0]  s2;
		logic [3:0]  s3;
		logic [3:0]  s4;
		int          flips;
		int          done;
		int          pos;
		msg       = 7'(draw_bits(msg_lfsr, 7));
		flips     = draw_bits(msg_lfsr, 2);
		flip_mask = '0;
		done      = 0;
		while (done < flips) begin
			pos = draw_bits(msg_lfsr, 4);
			if (pos < 15 && !flip_mask[pos]) begin
				flip_mask[pos] = 1'b1;
				done++;
			end
		end
		rx = encode_message(msg) ^ flip_mask;
		s1 = poly_eval(rx, 4'b0010);
		s3 = poly_eval(rx, 4'b1000);
		s2 = field_square(s1);
		s4 = field_square(s2);
		exp_res[idx].s1             = s1;
		exp_res[idx].s2             = s2;
		exp_res[idx].s3             = s3;
		exp_res[idx].s4             = s4;
		exp_res[idx].errors_present = (s1 | s2 | s3 | s4) != 4'h0;
		exp_res[idx].single_error   = (s1 != 4'h0) && (s3 == field_mul(s2, s1));
		exp_weight[idx]             = flips;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Edge counters for results and credits on both sides
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_idx       <= 0;
			cons_credits <= bch_pkg::OUT_CREDITS;
			src_back     <= 0;
		end else begin
			rx_idx       <= rx_idx + int'(out_valid);
			cons_credits <= cons_credits - int'(out_valid) + int'(out_credit);
			src_back     <= src_back + int'(in_credit);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_clean: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && head_weight == 0) |->
		({out_s1, out_s2, out_s3, out_s4} == '0 && !out_errors_present && !out_single_error))
		else begin
			mismatch_errors++;
			$display("mismatch at %0t: clean codeword %0d has nonzero syndromes or flags",
				$time, $sampled(rx_idx));
		end

	a_odd: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (out_s1 == exp_head.s1 && out_s3 == exp_head.s3))
		else begin
			mismatch_errors++;
			$display("mismatch at %0t: codeword %0d s1/s3 got %h/%h expected %h/%h", $time,
				$sampled(rx_idx), $sampled(out_s1), $sampled(out_s3),
				$sampled(exp_head.s1), $sampled(exp_head.s3));
		end

	a_even: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (out_s2 == exp_head.s2 && out_s4 == exp_head.s4))
		else begin
			mismatch_errors++;
			$display("mismatch at %0t: codeword %0d s2/s4 got %h/%h expected %h/%h", $time,
				$sampled(rx_idx), $sampled(out_s2), $sampled(out_s4),
				$sampled(exp_head.s2), $sampled(exp_head.s4));
		end

	a_flags: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (out_errors_present == exp_head.errors_present &&
			out_single_error == exp_head.single_error))
		else begin
			mismatch_errors++;
			$display("mismatch at %0t: codeword %0d flags got %b%b expected %b%b", $time,
				$sampled(rx_idx), $sampled(out_errors_present), $sampled(out_single_error),
				$sampled(exp_head.errors_present), $sampled(exp_head.single_error));
		end

	a_single: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && head_weight == 1) |-> (out_single_error && out_errors_present))
		else begin
			mismatch_errors++;
			$display("mismatch at %0t: one flipped bit not flagged as single error", $time);
		end

	a_double: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && head_weight == 2) |-> (!out_single_error && out_errors_present))
		else begin
			mismatch_errors++;
			$display("mismatch at %0t: two flipped bits flagged wrongly", $time);
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Flow control checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_cons_credit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> (cons_credits > 0 && rx_idx < NUM_CW))
		else begin
			protocol_errors++;
			$display("At %0t a result came out without a consumer credit or beyond the last one",
				$time);
		end

	a_src_credit: assert property (@(posedge clk) disable iff (!rst_n)
		(src_avail >= 0 && src_avail <= bch_pkg::IN_DEPTH))
		else begin
			protocol_errors++;
			$display("At %0t the source credit count left its range", $time);
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Source, consumer, control and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	initial begin : source
		logic [14:0] rx;
		int          w;
		in_valid   = 1'b0;
		in_first   = 1'b0;
		in_bits    = '0;
		words_sent = 0;
		msg_lfsr   = SEED;
		wait (rst_n === 1'b1);
		for (int c = 0; c < NUM_CW; c++) begin
			build_codeword(c, rx);
			w = 0;
			while (w < bch_pkg::WORDS_PER_CW) begin
				@(negedge clk);
				if (src_avail > 0) begin
					// Highest degree goes first
					in_valid = 1'b1;
					in_first = (w == 0);
					in_bits  = rx[14 - 3 * w -: 3];
					words_sent++;
					w++;
				end else begin
					in_valid = 1'b0;
				end
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
	end

	initial begin : consumer
		int delay_left;
		bit stalled;
		out_credit    = 1'b0;
		credits_given = 0;
		delay_left    = 0;
		stalled       = 1'b0;
		delay_lfsr    = SEED;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			out_credit = 1'b0;
			if (!stalled && rx_idx >= STALL_AT) begin
				// Long enough to back up both queues to the source
				stalled = 1'b1;
				repeat (STALL_LEN) @(negedge clk);
			end else if (credits_given < rx_idx) begin
				if (delay_left == 0) begin
					out_credit = 1'b1;
					credits_given++;
					delay_left = draw_bits(delay_lfsr, 3);
				end else begin
					delay_left--;
				end
			end
		end
	end

	initial begin : control
		rst_n           = 1'b0;
		mismatch_errors = 0;
		protocol_errors = 0;
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		wait (rx_idx == NUM_CW && credits_given == NUM_CW);
		repeat (20) @(negedge clk);
		assert (rx_idx == NUM_CW) else begin
			protocol_errors++;
			$display("Received %0d results instead of %0d", rx_idx, NUM_CW);
		end
		assert (src_avail == bch_pkg::IN_DEPTH) else begin
			protocol_errors++;
			$display("Source credits did not all return, %0d of %0d", src_avail,
				bch_pkg::IN_DEPTH);
		end
		$display("Errors: mismatch %0d, protocol %0d", mismatch_errors, protocol_errors);
		if (mismatch_errors + protocol_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(RUN_LIMIT);
		$display("The run timed out with %0d of %0d results received", rx_idx, NUM_CW);
		$display("Errors: mismatch %0d, protocol %0d", mismatch_errors, protocol_errors);
		$display("Test failed");
		$finish;
	end

endmodule
